// ==== rtl/vn_lut_settings.svh ====
`ifndef VN_LUT_SETTINGS_SVH
`define VN_LUT_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////

// Lanes in the array, two message ports each
`define VN_NUM_LANES 4

// Width of a lane index in a table write
`define VN_LANE_W 2

////////////////////////////////////////////////////////////
// Message and table fields
////////////////////////////////////////////////////////////

// Quantized message, sign in the top bit
`define VN_MSG_W 4

// Page address, one table half holds 2**VN_PAGE_W pages
`define VN_PAGE_W 6

`endif

// ==== rtl/vn_lut_pkg.sv ====
`include "vn_lut_settings.svh"

package vn_lut_pkg;

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////

	// Incoming message pair of one port
	typedef struct packed {
		logic [`VN_MSG_W-1:0] y0;
		logic [`VN_MSG_W-1:0] y1;
	} vn_in_t;

	// Folded pair, y0 sign already stripped
	typedef struct packed {
		logic [`VN_MSG_W-2:0] y0_mag;
		logic [`VN_MSG_W-1:0] y1;
	} vn_pair_msg_t;

	// Same seven bits seen as table address
	typedef struct packed {
		logic [`VN_PAGE_W-1:0] page;
		logic                  bank;
	} vn_pair_addr_t;

	typedef union packed {
		vn_pair_msg_t  msg;
		vn_pair_addr_t addr;
	} vn_pair_u;

	// Raw lane lookup, sign not yet restored
	typedef struct packed {
		logic [`VN_MSG_W-1:0] t_c;
		logic                 transpose_en;
	} vn_lane_out_t;

	// Final result after unfolding
	typedef struct packed {
		logic [`VN_MSG_W-1:0] msg;
		logic                 transpose_en;
	} vn_res_t;

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////

	// One table write, both banks at once
	typedef struct packed {
		logic [`VN_LANE_W-1:0] lane;
		logic                  broadcast;
		logic                  offset;
		logic [`VN_PAGE_W-1:0] page;
		logic [`VN_MSG_W-1:0]  data0;
		logic [`VN_MSG_W-1:0]  data1;
	} lut_wr_t;

endpackage

// ==== rtl/lut_load_ctrl.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module lut_load_ctrl
	import vn_lut_pkg::*;
(
	input  logic                     read_clk,
	input  logic                     rst_n,
	input  logic                     wr_en,
	input  lut_wr_t                  wr,
	output logic [`VN_NUM_LANES-1:0] lane_we,
	output lut_wr_t                  wr_q
);

	////////////////////////////////////////////////////////////
	// Lane select decode
	////////////////////////////////////////////////////////////

	// Next-cycle write enables, one per lane
	logic [`VN_NUM_LANES-1:0] lane_we_d;

	always_comb begin
		lane_we_d = '0;
		if (wr_en) begin
			// Broadcast loads every lane in one go
			if (wr.broadcast) begin
				lane_we_d = '1;
			end else begin
				lane_we_d[wr.lane] = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Request register
	////////////////////////////////////////////////////////////

	// Enables are control state
	always_ff @(posedge read_clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_we <= '0;
		end else begin
			lane_we <= lane_we_d;
		end
	end

	// Address and data shared by all lanes
	always_ff @(posedge read_clk) begin
		if (wr_en) begin
			wr_q <= wr;
		end
	end

	// Lanes commit on the edge after this one

endmodule

// ==== rtl/sym_vn_rank.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module sym_vn_rank
	import vn_lut_pkg::*;
(
	input  logic                 read_clk,
	input  vn_pair_u             rd_addr0,
	input  vn_pair_u             rd_addr1,
	input  logic                 rd_offset,
	output logic [`VN_MSG_W-1:0] rd_data0,
	output logic [`VN_MSG_W-1:0] rd_data1,
	input  logic                 we,
	input  lut_wr_t              wr
);

	// Offset bit on top of page
	localparam int IDX_W   = `VN_PAGE_W + 1;
	localparam int ENTRIES = 2 ** IDX_W;

	////////////////////////////////////////////////////////////
	// Table storage
	////////////////////////////////////////////////////////////

	// Bank 0 and bank 1, each two offsets of pages
	logic [`VN_MSG_W-1:0] mem [2][ENTRIES];

	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx0;
	logic [IDX_W-1:0] rd_idx1;

	assign wr_idx = {wr.offset, wr.page};

	// Both banks written at the same entry
	always_ff @(posedge read_clk) begin
		if (we) begin
			mem[0][wr_idx] <= wr.data0;
			mem[1][wr_idx] <= wr.data1;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	// Offset picks the table set
	assign rd_idx0 = {rd_offset, rd_addr0.addr.page};
	assign rd_idx1 = {rd_offset, rd_addr1.addr.page};

	// Asynchronous read
	// bank bit of the folded word picks the bank
	assign rd_data0 = mem[rd_addr0.addr.bank][rd_idx0];
	assign rd_data1 = mem[rd_addr1.addr.bank][rd_idx1];

endmodule

// ==== rtl/sym_vn_lut_in.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module sym_vn_lut_in
	import vn_lut_pkg::*;
(
	input  logic         read_clk,
	input  logic         rst_n,
	input  vn_in_t       in_a,
	input  vn_in_t       in_b,
	input  logic         rd_offset,
	input  logic         we,
	input  lut_wr_t      wr,
	output vn_lane_out_t out_a,
	output vn_lane_out_t out_b,
	output logic         rd_offset_out
);

	////////////////////////////////////////////////////////////
	// Symmetry fold
	////////////////////////////////////////////////////////////

	// Negative y0 mirrors the whole pair
	function automatic vn_pair_u fold_pair(input vn_in_t m);
		vn_pair_u p;
		logic     s;
		s = m.y0[`VN_MSG_W-1];
		p.msg.y0_mag = m.y0[`VN_MSG_W-2:0] ^ {(`VN_MSG_W-1){s}};
		p.msg.y1 = m.y1 ^ {`VN_MSG_W{s}};
		return p;
	endfunction

	// Index 0 is port A, index 1 port B
	vn_pair_u [1:0]                pair_s0;
	logic     [1:0]                te_s0;
	logic                          off_s0;
	logic     [1:0][`VN_MSG_W-1:0] rd_data;
	logic     [1:0][`VN_MSG_W-1:0] t_c_s1;
	logic     [1:0]                te_s1;
	logic                          off_s1;

	////////////////////////////////////////////////////////////
	// Stage 0
	////////////////////////////////////////////////////////////

	always_ff @(posedge read_clk or negedge rst_n) begin
		if (!rst_n) begin
			pair_s0 <= '0;
			te_s0   <= '0;
			off_s0  <= 1'b0;
		end else begin
			pair_s0[0] <= fold_pair(in_a);
			pair_s0[1] <= fold_pair(in_b);
			// Sign kept aside for unfolding
			te_s0  <= {in_b.y0[`VN_MSG_W-1], in_a.y0[`VN_MSG_W-1]};
			off_s0 <= rd_offset;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 1
	////////////////////////////////////////////////////////////

	// Private table copy of this lane
	sym_vn_rank u_rank (
		.read_clk  (read_clk),
		.rd_addr0  (pair_s0[0]),
		.rd_addr1  (pair_s0[1]),
		.rd_offset (off_s0),
		.rd_data0  (rd_data[0]),
		.rd_data1  (rd_data[1]),
		.we        (we),
		.wr        (wr)
	);

	// Lookup result plus sideband
	always_ff @(posedge read_clk or negedge rst_n) begin
		if (!rst_n) begin
			t_c_s1 <= '0;
			te_s1  <= '0;
			off_s1 <= 1'b0;
		end else begin
			t_c_s1 <= rd_data;
			te_s1  <= te_s0;
			off_s1 <= off_s0;
		end
	end

	// Lane outputs, straight from stage 1
	assign out_a.t_c          = t_c_s1[0];
	assign out_a.transpose_en = te_s1[0];
	assign out_b.t_c          = t_c_s1[1];
	assign out_b.transpose_en = te_s1[1];
	assign rd_offset_out      = off_s1;

endmodule

// ==== rtl/vn_msg_unfold.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module vn_msg_unfold
	import vn_lut_pkg::*;
(
	input  logic                                 read_clk,
	input  logic                                 rst_n,
	input  vn_lane_out_t [2*`VN_NUM_LANES-1:0]   lane_out,
	input  logic                                 lane_offset,
	output vn_res_t      [2*`VN_NUM_LANES-1:0]   res,
	output logic                                 rd_offset_out
);

	// Two message ports per lane
	localparam int NUM_PORTS = 2 * `VN_NUM_LANES;

	vn_res_t [NUM_PORTS-1:0] res_d;

	////////////////////////////////////////////////////////////
	// Sign restore
	////////////////////////////////////////////////////////////

	// Mirrored lookups come back inverted
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			res_d[i].msg = lane_out[i].t_c ^ {`VN_MSG_W{lane_out[i].transpose_en}};
			res_d[i].transpose_en = lane_out[i].transpose_en;
		end
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge read_clk or negedge rst_n) begin
		if (!rst_n) begin
			res           <= '0;
			rd_offset_out <= 1'b0;
		end else begin
			res           <= res_d;
			// Offset rides along, same for every lane
			rd_offset_out <= lane_offset;
		end
	end

	// Third pipeline edge, latency 3 overall

endmodule

// ==== rtl/vn_lut_array.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module vn_lut_array
	import vn_lut_pkg::*;
(
	input  logic                             read_clk,
	input  logic                             rst_n,
	input  logic                             wr_en,
	input  lut_wr_t                          wr,
	input  vn_in_t  [2*`VN_NUM_LANES-1:0]    rd_msg,
	input  logic                             rd_offset,
	output vn_res_t [2*`VN_NUM_LANES-1:0]    res,
	output logic                             rd_offset_out
);

	logic [`VN_NUM_LANES-1:0]            lane_we;
	lut_wr_t                             wr_q;
	vn_lane_out_t [2*`VN_NUM_LANES-1:0]  lane_out;
	logic [`VN_NUM_LANES-1:0]            lane_offset;

	////////////////////////////////////////////////////////////
	// Table load path
	////////////////////////////////////////////////////////////

	lut_load_ctrl u_load (
		.read_clk (read_clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr       (wr),
		.lane_we  (lane_we),
		.wr_q     (wr_q)
	);

	////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////

	// Even port is A, odd port is B
	for (genvar i = 0; i < `VN_NUM_LANES; i++) begin : g_lane
		sym_vn_lut_in u_lane (
			.read_clk      (read_clk),
			.rst_n         (rst_n),
			.in_a          (rd_msg[2*i]),
			.in_b          (rd_msg[2*i+1]),
			.rd_offset     (rd_offset),
			.we            (lane_we[i]),
			.wr            (wr_q),
			.out_a         (lane_out[2*i]),
			.out_b         (lane_out[2*i+1]),
			.rd_offset_out (lane_offset[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////

	// Lane 0 speaks for the shared offset
	vn_msg_unfold u_unfold (
		.read_clk      (read_clk),
		.rst_n         (rst_n),
		.lane_out      (lane_out),
		.lane_offset   (lane_offset[0]),
		.res           (res),
		.rd_offset_out (rd_offset_out)
	);

endmodule

// ==== sim/vn_lut_array_checker.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module vn_lut_array_checker
	import vn_lut_pkg::*;
(
	input logic                            read_clk,
	input logic                            rst_n,
	input logic                            wr_en,
	input lut_wr_t                         wr,
	input vn_in_t  [2*`VN_NUM_LANES-1:0]   rd_msg,
	input logic                            rd_offset,
	input vn_res_t [2*`VN_NUM_LANES-1:0]   res,
	input logic                            rd_offset_out
);

	localparam int NUM_PORTS = 2 * `VN_NUM_LANES;
	localparam int PAGES     = 2 ** `VN_PAGE_W;
	localparam int WORD_W    = 2 * `VN_MSG_W - 1;

	// Shadow tables, lane then offset then bank then page
	logic [`VN_MSG_W-1:0] shadow [`VN_NUM_LANES][2][2][PAGES];

	// Expected results for the three reads in flight
	vn_res_t [NUM_PORTS-1:0] exp_q [3];
	logic    [2:0]           off_q;
	logic    [2:0]           vld_q;

	// Failure tally, read by the testbench
	int err_cnt = 0;

	// Mirror on negative y0, look up, then mirror the result back
	function automatic vn_res_t expect_res(input int lane, input vn_in_t m, input logic off);
		logic              neg;
		logic [WORD_W-1:0] word;
		vn_res_t           r;
		neg = m.y0[`VN_MSG_W-1];
		word = {m.y0[`VN_MSG_W-2:0], m.y1} ^ {WORD_W{neg}};
		// Page is the upper six bits, bank the lowest
		r.msg = shadow[lane][off][word[0]][word[WORD_W-1:1]] ^ {`VN_MSG_W{neg}};
		r.transpose_en = neg;
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Shadow table and read history
	////////////////////////////////////////////////////////////

	always_ff @(posedge read_clk) begin
		if (wr_en) begin
			for (int l = 0; l < `VN_NUM_LANES; l++) begin
				if (wr.broadcast || int'(wr.lane) == l) begin
					shadow[l][wr.offset][0][wr.page] <= wr.data0;
					shadow[l][wr.offset][1][wr.page] <= wr.data1;
				end
			end
		end
	end

	// Expectation taken when the DUT samples the read
	always_ff @(posedge read_clk or negedge rst_n) begin
		if (!rst_n) begin
			off_q <= '0;
			vld_q <= '0;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				exp_q[0][p] <= expect_res(p / 2, rd_msg[p], rd_offset);
			end
			exp_q[1] <= exp_q[0];
			exp_q[2] <= exp_q[1];
			off_q    <= {off_q[1:0], rd_offset};
			vld_q    <= {vld_q[1:0], 1'b1};
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		// Restored message of the read three edges back
		a_msg: assert property (@(posedge read_clk) disable iff (!rst_n)
			vld_q[2] |-> res[p].msg === exp_q[2][p].msg)
		else begin
			err_cnt++;
			$error("ERROR res[%0d].msg expected %h got %h", p,
				$sampled(exp_q[2][p].msg), $sampled(res[p].msg));
		end

		// Sign flag follows y0, low while the pipe fills
		a_te: assert property (@(posedge read_clk) disable iff (!rst_n)
			res[p].transpose_en === (vld_q[2] & exp_q[2][p].transpose_en))
		else begin
			err_cnt++;
			$error("ERROR res[%0d].transpose_en expected %h got %h", p,
				$sampled(vld_q[2] & exp_q[2][p].transpose_en),
				$sampled(res[p].transpose_en));
		end

		// First lookup still on its way
		a_idle: assert property (@(posedge read_clk) disable iff (!rst_n)
			!vld_q[2] |-> res[p].msg === '0)
		else begin
			err_cnt++;
			$error("ERROR res[%0d].msg expected 0 got %h", p, $sampled(res[p].msg));
		end
	end

	a_offset: assert property (@(posedge read_clk) disable iff (!rst_n)
		rd_offset_out === (vld_q[2] & off_q[2]))
	else begin
		err_cnt++;
		$error("ERROR rd_offset_out expected %h got %h",
			$sampled(vld_q[2] & off_q[2]), $sampled(rd_offset_out));
	end

endmodule

// ==== sim/vn_lut_array_tb.sv ====
`timescale 1ns/1ps
`include "vn_lut_settings.svh"

module vn_lut_array_tb
	import vn_lut_pkg::*;
();

	localparam int NUM_PORTS  = 2 * `VN_NUM_LANES;
	localparam int CLK_NS     = 4;
	// Both offsets of every page
	localparam int LOAD_LEN   = 2 * (2 ** `VN_PAGE_W);
	localparam int READ_LEN   = 200;
	localparam int DRAIN      = 4;
	// Reset, per-lane loads, broadcast load, two read runs, probes
	localparam int RUN_CYCLES = 4 + 8 + (`VN_NUM_LANES + 1) * (LOAD_LEN + 1)
		+ 2 * (READ_LEN + DRAIN) + 3 * (4 + DRAIN) + 2 + 3 * DRAIN;
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_NS;

	logic                     read_clk;
	logic                     rst_n;
	logic                     wr_en;
	lut_wr_t                  wr;
	vn_in_t  [NUM_PORTS-1:0]  rd_msg;
	logic                     rd_offset;
	vn_res_t [NUM_PORTS-1:0]  res;
	logic                     rd_offset_out;

	int tests_run = 0;
	int tests_failed = 0;

	vn_lut_array dut0 (
		.read_clk      (read_clk),
		.rst_n         (rst_n),
		.wr_en         (wr_en),
		.wr            (wr),
		.rd_msg        (rd_msg),
		.rd_offset     (rd_offset),
		.res           (res),
		.rd_offset_out (rd_offset_out)
	);

	bind vn_lut_array vn_lut_array_checker chk (
		.read_clk      (read_clk),
		.rst_n         (rst_n),
		.wr_en         (wr_en),
		.wr            (wr),
		.rd_msg        (rd_msg),
		.rd_offset     (rd_offset),
		.res           (res),
		.rd_offset_out (rd_offset_out)
	);

	initial begin
		read_clk = 1'b0;
		forever #(CLK_NS / 2) read_clk = ~read_clk;
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic idle(input int n);
		repeat (n) @(posedge read_clk);
	endtask

	task automatic present_write(input lut_wr_t w);
		@(posedge read_clk);
		wr_en <= 1'b1;
		wr    <= w;
	endtask

	task automatic stop_writes();
		@(posedge read_clk);
		wr_en <= 1'b0;
	endtask

	// Random contents for every entry of one lane, or of all lanes
	task automatic load_table(input int lane, input logic bcast);
		lut_wr_t     w;
		logic [31:0] r;
		for (int i = 0; i < LOAD_LEN; i++) begin
			r = $urandom;
			w.lane      = lane[`VN_LANE_W-1:0];
			w.broadcast = bcast;
			w.offset    = i[`VN_PAGE_W];
			w.page      = i[`VN_PAGE_W-1:0];
			w.data0     = r[3:0];
			w.data1     = r[7:4];
			present_write(w);
		end
		stop_writes();
	endtask

	// Every fourth cycle port B of each lane gets the complement of port A
	task automatic random_reads(input int n);
		vn_in_t [NUM_PORTS-1:0] m;
		logic   [31:0]          r;
		for (int c = 0; c < n; c++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				r = $urandom;
				m[p] = r[7:0];
				if (p % 2 == 1 && c % 4 == 0) begin
					m[p] = ~m[p-1];
				end
			end
			r = $urandom;
			@(posedge read_clk);
			rd_msg    <= m;
			rd_offset <= r[0];
		end
		idle(DRAIN);
	endtask

	// One entry on all lanes, both banks, plain and mirrored
	task automatic probe_entry(input logic off, input logic [`VN_PAGE_W-1:0] page);
		vn_in_t [NUM_PORTS-1:0] m;
		for (int k = 0; k < 4; k++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				m[p].y0 = {1'b0, page[5:3]};
				m[p].y1 = {page[2:0], k[0]};
				if (k[1]) begin
					m[p] = ~m[p];
				end
			end
			@(posedge read_clk);
			rd_msg    <= m;
			rd_offset <= off;
		end
		idle(DRAIN);
	endtask

	task automatic report(input string name, input int base);
		int delta;
		delta = dut0.chk.err_cnt - base;
		tests_run++;
		if (delta != 0) begin
			tests_failed++;
		end
		$display("test %-10s %s, %0d assertion failures", name,
			(delta == 0) ? "passed" : "failed", delta);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int      base;
		lut_wr_t w;
		rst_n     = 1'b0;
		wr_en     = 1'b0;
		wr        = '0;
		rd_msg    = '0;
		rd_offset = 1'b0;
		void'($urandom(32'h223b_a423));
		repeat (4) @(posedge read_clk);
		rst_n <= 1'b1;

		// Outputs stay quiet while the pipe fills
		base = dut0.chk.err_cnt;
		idle(8);
		report("reset", base);

		base = dut0.chk.err_cnt;
		for (int l = 0; l < `VN_NUM_LANES; l++) begin
			load_table(l, 1'b0);
		end
		idle(DRAIN);
		random_reads(READ_LEN);
		report("lane_load", base);

		// Lane 2 alone gets a new word at offset 1, page 0x2d
		base = dut0.chk.err_cnt;
		probe_entry(1'b1, 6'h2d);
		w           = '0;
		w.lane      = 2'd2;
		w.offset    = 1'b1;
		w.page      = 6'h2d;
		w.data0     = 4'h9;
		w.data1     = 4'h6;
		present_write(w);
		stop_writes();
		idle(DRAIN);
		probe_entry(1'b1, 6'h2d);
		// Same page under the other offset keeps its old words
		probe_entry(1'b0, 6'h2d);
		report("lane_write", base);

		base = dut0.chk.err_cnt;
		load_table(0, 1'b1);
		idle(DRAIN);
		random_reads(READ_LEN);
		report("broadcast", base);

		$display("tests %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, dut0.chk.err_cnt);
		if (tests_failed == 0 && dut0.chk.err_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

// ==== vn_lut_array.f ====
+incdir+rtl
rtl/vn_lut_pkg.sv
rtl/lut_load_ctrl.sv
rtl/sym_vn_rank.sv
rtl/sym_vn_lut_in.sv
rtl/vn_msg_unfold.sv
rtl/vn_lut_array.sv
sim/vn_lut_array_checker.sv
sim/vn_lut_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timing -f vn_lut_array.f \
	--top-module vn_lut_array_tb -o vn_lut_array_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/vn_lut_array_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
	exit 0
fi
exit 1
